//--- filelist.f
+incdir+hdl
hdl/riscv_pkg.sv
hdl/alu.sv
hdl/imm_ext.sv
hdl/regfile.sv
hdl/datapath.sv
hdl/controller.sv
hdl/riscv_core.sv
tests/tb_clock.sv
tests/tb_riscv_core.sv

//--- Bender.yml
package:
  name: riscv_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/riscv_pkg.sv
      - hdl/alu.sv
      - hdl/imm_ext.sv
      - hdl/regfile.sv
      - hdl/datapath.sv
      - hdl/controller.sv
      - hdl/riscv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock.sv
      - tests/tb_riscv_core.sv

//--- tests/tb_riscv_core.sv
`default_nettype none

`include "riscv_consts.svh"

module tb_riscv_core;

    logic clk, rst_n, rst_req, mem_we;
    riscv_pkg::word_t instr_addr, instr, data_addr, write_data, read_data;
    riscv_pkg::word_t imem [64];
    riscv_pkg::word_t dmem [64];
    riscv_pkg::word_t data_init [4]; // copied to dmem words 0..3 at each start
    riscv_pkg::word_t prog [$];
    riscv_pkg::word_t fetch_log [$]; // pc of every executed instruction
    riscv_pkg::word_t store_pcs [$];

    localparam logic [2:0] r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    localparam logic r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
    localparam logic [2:0] i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
    localparam logic i_alt [9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
    localparam logic [2:0] br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    localparam riscv_pkg::word_t pair_a [4] = '{5, 32'hffff_ffff, 1, 32'h7fff_ffff};
    localparam riscv_pkg::word_t pair_b [4] = '{5, 1, 32'h8000_0000, 32'h8000_0000};
    localparam int jump_path [5] = '{0, 16, 20, 24, 36};

    tb_clock clk0 (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

    riscv_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_we     (mem_we),
        .read_data  (read_data)
    );

    // both memories read combinationally
    assign instr     = imem[instr_addr[7:2]];
    assign read_data = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (rst_n) begin
            fetch_log.push_back(instr_addr);
            if (mem_we) begin
                dmem[data_addr[7:2]] <= write_data;
                store_pcs.push_back(instr_addr);
            end
        end
    end

    function automatic riscv_pkg::word_t fill_word(input int addr);
        return 32'ha5a5_0000 | addr[15:0];
    endfunction

    function automatic riscv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic riscv_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op}; // also lw and jalr
    endfunction

    function automatic riscv_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic riscv_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic riscv_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic riscv_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OP_AUIPC};
    endfunction

    function automatic void emit(input riscv_pkg::word_t w);
        prog.push_back(w);
    endfunction

    // reference results straight from the ISA definitions
    function automatic riscv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
        input riscv_pkg::word_t a, input riscv_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                else return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input riscv_pkg::word_t a,
        input riscv_pkg::word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_eq(input string name, input riscv_pkg::word_t got,
        input riscv_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input int addr, input riscv_pkg::word_t exp);
        check_eq($sformatf("dmem[0x%0h]", addr), dmem[addr >> 2], exp);
    endtask

    task automatic check_fetch(input int idx, input riscv_pkg::word_t exp);
        if (idx >= fetch_log.size()) begin
            $display("Only %0d instructions executed, fetch %0d missing", fetch_log.size(), idx);
            stop_on_error();
        end else begin
            check_eq($sformatf("instr_addr[%0d]", idx), fetch_log[idx], exp);
        end
    endtask

    // reset, load memories while in reset, run up to the final self loop
    task automatic run_program();
        int t;
        riscv_pkg::word_t end_addr;
        end_addr = 4 * (prog.size() - 1);
        rst_req = 1'b1;
        t = 0;
        while (rst_n !== 1'b0) begin
            @(negedge clk);
            t++;
            if (t > 10) begin
                $display("Reset did not assert after the request");
                stop_on_error();
            end
        end
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : {i[24:0], 7'h7f}; // unused opcode
            dmem[i] = (i < 4) ? data_init[i] : fill_word(i * 4);
        end
        fetch_log.delete();
        store_pcs.delete();
        rst_req = 1'b0;
        t = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            t++;
            if (t > 10) begin
                $display("Reset was never released");
                stop_on_error();
            end
        end
        t = 0;
        while (instr_addr !== end_addr) begin
            @(negedge clk);
            t++;
            if (t > 500) begin
                $display("Core hung, end loop at 0x%h never reached", end_addr);
                stop_on_error();
            end
        end
        check_fetch(0, 32'h0);
    endtask

    task automatic alu_results();
        riscv_pkg::word_t a, b;
        logic [11:0] imm [9];
        for (int round = 0; round < 4; round++) begin
            a = $urandom;
            b = $urandom;
            data_init[0] = a;
            data_init[1] = b;
            prog.delete();
            emit(i_type(0, 0, 3'b010, 1, `OP_LOAD));
            emit(i_type(4, 0, 3'b010, 2, `OP_LOAD));
            for (int k = 0; k < 10; k++) begin
                emit(r_type({1'b0, r_alt[k], 5'b0}, 2, 1, r_f3[k], 3));
                emit(s_type(64 + 4 * k, 3, 0));
            end
            for (int k = 0; k < 9; k++) begin
                imm[k] = $urandom;
                if (i_f3[k] == 3'b001 || i_f3[k] == 3'b101) begin
                    imm[k] = {1'b0, i_alt[k], 5'b0, imm[k][4:0]}; // shamt form
                end
                emit(i_type(imm[k], 1, i_f3[k], 3, `OP_IMM));
                emit(s_type(128 + 4 * k, 3, 0));
            end
            emit(j_type(0, 0));
            run_program();
            for (int k = 0; k < 10; k++) begin
                check_word(64 + 4 * k, alu_model(r_f3[k], r_alt[k], a, b));
            end
            for (int k = 0; k < 9; k++) begin
                check_word(128 + 4 * k,
                    alu_model(i_f3[k], i_alt[k], a, {{20{imm[k][11]}}, imm[k]}));
            end
        end
    endtask

    task automatic load_and_x0();
        riscv_pkg::word_t c;
        c = $urandom | 32'h1; // never zero
        data_init[2] = c;
        prog.delete();
        emit(i_type(8, 0, 3'b010, 5, `OP_LOAD));
        emit(s_type(200, 5, 0));
        emit(i_type(8, 0, 3'b010, 0, `OP_LOAD)); // into x0
        emit(s_type(204, 0, 0));
        emit(j_type(0, 0));
        run_program();
        check_word(200, c);
        check_word(204, 32'h0);
    endtask

    task automatic branch_decisions();
        riscv_pkg::word_t a, b;
        logic taken;
        for (int p = 0; p < 8; p++) begin
            a = (p < 4) ? pair_a[p] : pair_b[p - 4]; // second half swaps the pair
            b = (p < 4) ? pair_b[p] : pair_a[p - 4];
            for (int k = 0; k < 6; k++) begin
                data_init[0] = a;
                data_init[1] = b;
                taken = branch_taken(br_f3[k], a, b);
                prog.delete();
                emit(i_type(0, 0, 3'b010, 1, `OP_LOAD));
                emit(i_type(4, 0, 3'b010, 2, `OP_LOAD));
                emit(b_type(12, 2, 1, br_f3[k]));    // to 20
                emit(i_type(1, 0, 3'b000, 4, `OP_IMM));
                emit(j_type(8, 0));
                emit(i_type(2, 0, 3'b000, 4, `OP_IMM));
                emit(s_type(64, 4, 0));
                emit(j_type(0, 0));
                run_program();
                check_fetch(3, taken ? 32'd20 : 32'd12);
                check_word(64, taken ? 32'd2 : 32'd1);
            end
        end
    endtask

    task automatic jump_targets();
        prog.delete();
        emit(j_type(16, 1));
        repeat (3) emit(i_type(0, 0, 3'b000, 0, `OP_IMM));
        emit(s_type(64, 1, 0));
        emit(i_type(33, 0, 3'b000, 5, `OP_IMM));
        emit(i_type(4, 5, 3'b000, 2, `OP_JALR)); // target 37 lands on 36
        emit(i_type(99, 0, 3'b000, 7, `OP_IMM));
        emit(s_type(72, 7, 0));
        emit(s_type(68, 2, 0));
        emit(j_type(0, 0));
        run_program();
        for (int i = 0; i < 5; i++) begin
            check_fetch(i, jump_path[i]);
        end
        check_word(64, 32'd4);
        check_word(68, 32'd28);
        check_word(72, fill_word(72));
    endtask

    task automatic auipc_and_reset();
        logic [19:0] up;
        up = $urandom;
        prog.delete();
        repeat (2) emit(i_type(0, 0, 3'b000, 0, `OP_IMM));
        emit(u_type(up, 3));
        emit(s_type(64, 3, 0));
        emit(j_type(0, 0));
        run_program();
        check_word(64, 32'd8 + {up, 12'b0});
        check_eq("store count", store_pcs.size(), 1);
        check_eq("first store pc", store_pcs[0], 32'd12);
    endtask

    initial begin
        rst_req = 1'b0;
        void'($urandom(32'h5e39_d267));
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'h7f};
            dmem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < 4; i++) begin
            data_init[i] = '0;
        end
        @(negedge clk);
        auipc_and_reset();
        alu_results();
        load_and_x0();
        branch_decisions();
        jump_targets();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
    input  wire  rst_req, // rising edge starts a new reset pulse
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // rst_n only moves on falling edges, low for three cycles
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (3) @(negedge clk);
            rst_n = 1'b1;
            @(posedge rst_req);
            @(negedge clk);
            rst_n = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/riscv_core.sv
`default_nettype none

module riscv_core (
    input  wire                   clk,
    input  wire                   rst_n,

    // instruction memory, combinational read
    output wire riscv_pkg::word_t instr_addr,
    input  wire riscv_pkg::word_t instr,

    // data memory, written on the clock edge while mem_we is high
    output wire riscv_pkg::word_t data_addr,
    output wire riscv_pkg::word_t write_data,
    output wire                   mem_we,
    input  wire riscv_pkg::word_t read_data
);

    riscv_pkg::ctrl_t      ctrl;
    riscv_pkg::alu_flags_t alu_flags;

    controller ctrl0 (
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    datapath dp0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (instr_addr),
        .alu_flags  (alu_flags),
        .alu_result (data_addr),  // load/store address
        .write_data (write_data)
    );

    assign mem_we = ctrl.mem_we;

endmodule

`default_nettype wire

//--- hdl/controller.sv
`default_nettype none

`include "riscv_consts.svh"

module controller (
    input  wire riscv_pkg::word_t      instr,
    input  wire riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t           ctrl
);

    riscv_pkg::opcode_t opcode;
    logic [2:0]         func3;
    logic               func7_5;
    logic               taken;
    riscv_pkg::pc_src_e pc_src_branch;

    assign opcode  = instr[6:0];
    assign func3   = instr[14:12];
    assign func7_5 = instr[30];

    // alu decode: only reg and imm ops look at func3
    function automatic riscv_pkg::alu_op_e alu_decode(
        input riscv_pkg::opcode_t op,
        input logic [2:0]         f3,
        input logic               f7_5
    );
        riscv_pkg::alu_op_e sel;
        case (f3)
            3'b000:  sel = (op == `OP_REG && f7_5) ? riscv_pkg::alu_op_sub
                                                   : riscv_pkg::alu_op_add;
            3'b001:  sel = riscv_pkg::alu_op_sll;
            3'b010:  sel = riscv_pkg::alu_op_slt;
            3'b011:  sel = riscv_pkg::alu_op_sltu;
            3'b100:  sel = riscv_pkg::alu_op_xor;
            3'b101:  sel = f7_5 ? riscv_pkg::alu_op_sra : riscv_pkg::alu_op_srl;
            3'b110:  sel = riscv_pkg::alu_op_or;
            default: sel = riscv_pkg::alu_op_and;
        endcase
        if (op == `OP_BRANCH) begin
            sel = riscv_pkg::alu_op_sub; // compare through the flags
        end else if (op != `OP_REG && op != `OP_IMM) begin
            sel = riscv_pkg::alu_op_add; // address or pc arithmetic
        end
        return sel;
    endfunction

    // branch condition from the subtract flags
    always_comb begin
        case (func3)
            3'b000:  taken = alu_flags.zero;                      // beq
            3'b001:  taken = !alu_flags.zero;                     // bne
            3'b100:  taken = alu_flags.neg ^ alu_flags.ovf;       // blt
            3'b101:  taken = !(alu_flags.neg ^ alu_flags.ovf);    // bge
            3'b110:  taken = !alu_flags.cout;                     // bltu, borrow
            3'b111:  taken = alu_flags.cout;                      // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_src_branch = taken ? riscv_pkg::pc_src_plus_off : riscv_pkg::pc_src_plus_4;

    // main decode
    always_comb begin
        ctrl.reg_we     = 1'b0;
        ctrl.mem_we     = 1'b0;
        ctrl.alu_src    = riscv_pkg::alu_src_reg;
        ctrl.result_src = riscv_pkg::res_src_alu_out;
        ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
        ctrl.imm_src    = riscv_pkg::imm_src_itype;
        ctrl.alu_ctrl   = alu_decode(opcode, func3, func7_5);
        case (opcode)
            `OP_LOAD: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = riscv_pkg::alu_src_ext_imm;
                ctrl.result_src = riscv_pkg::res_src_read_data;
            end
            `OP_IMM: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = riscv_pkg::alu_src_ext_imm;
            end
            `OP_STORE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.alu_src = riscv_pkg::alu_src_ext_imm;
                ctrl.imm_src = riscv_pkg::imm_src_stype;
            end
            `OP_REG:    ctrl.reg_we = 1'b1;
            `OP_BRANCH: begin
                ctrl.pc_src  = pc_src_branch;
                ctrl.imm_src = riscv_pkg::imm_src_btype;
            end
            `OP_JAL: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = riscv_pkg::res_src_pc_plus_4;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_off;
                ctrl.imm_src    = riscv_pkg::imm_src_jtype;
            end
            `OP_JALR: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = riscv_pkg::res_src_pc_plus_4;
                ctrl.pc_src     = riscv_pkg::pc_src_reg_plus_off; // own adder in datapath
            end
            `OP_AUIPC: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = riscv_pkg::alu_src_pc_ext_imm;
                ctrl.imm_src = riscv_pkg::imm_src_utype;
            end
            default: ; // unsupported opcode, no state change
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`default_nettype none

module datapath (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire riscv_pkg::ctrl_t  ctrl,
    input  wire riscv_pkg::word_t  instr,
    input  wire riscv_pkg::word_t  read_data,
    output riscv_pkg::word_t       pc,
    output riscv_pkg::alu_flags_t  alu_flags,
    output riscv_pkg::word_t       alu_result,
    output riscv_pkg::word_t       write_data
);

    riscv_pkg::word_t pc_next;
    riscv_pkg::word_t pc_plus_4;
    riscv_pkg::word_t pc_plus_off;
    riscv_pkg::word_t reg_plus_off;
    riscv_pkg::word_t imm;
    riscv_pkg::word_t rd1;
    riscv_pkg::word_t rd2;
    riscv_pkg::word_t src_a;
    riscv_pkg::word_t src_b;
    riscv_pkg::word_t result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus_4    = pc + 32'd4;
    assign pc_plus_off  = pc + imm;     // branches and jal
    assign reg_plus_off = rd1 + imm;    // jalr, independent of the alu

    always_comb begin
        case (ctrl.pc_src)
            riscv_pkg::pc_src_plus_off:     pc_next = pc_plus_off;
            riscv_pkg::pc_src_reg_plus_off: pc_next = {reg_plus_off[31:1], 1'b0};
            default:                        pc_next = pc_plus_4;
        endcase
    end

    regfile rf0 (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (instr[19:15]),
        .ra2   (instr[24:20]),
        .wa    (instr[11:7]),
        .we    (ctrl.reg_we),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    imm_ext ext0 (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    // a is the pc only for auipc
    assign src_a = (ctrl.alu_src == riscv_pkg::alu_src_pc_ext_imm) ? pc : rd1;
    assign src_b = (ctrl.alu_src == riscv_pkg::alu_src_reg) ? rd2 : imm;

    alu alu0 (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (ctrl.result_src)
            riscv_pkg::res_src_read_data: result = read_data;
            riscv_pkg::res_src_pc_plus_4: result = pc_plus_4; // link
            default:                      result = alu_result;
        endcase
    end

    assign write_data = rd2; // store data

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none

`include "riscv_consts.svh"

module regfile (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire riscv_pkg::reg_addr_t  ra1,
    input  wire riscv_pkg::reg_addr_t  ra2,
    input  wire riscv_pkg::reg_addr_t  wa,
    input  wire                        we,
    input  wire riscv_pkg::word_t      wd,
    output riscv_pkg::word_t           rd1,
    output riscv_pkg::word_t           rd2
);

    riscv_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    // async read
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

`default_nettype wire

//--- hdl/imm_ext.sv
`default_nettype none

module imm_ext (
    input  wire riscv_pkg::word_t    instr,
    input  wire riscv_pkg::imm_src_e imm_src,
    output riscv_pkg::word_t         imm
);

    logic s; // sign bit, always instr[31]

    assign s = instr[31];

    always_comb begin
        case (imm_src)
            riscv_pkg::imm_src_stype:
                imm = {{20{s}}, instr[31:25], instr[11:7]};
            riscv_pkg::imm_src_btype: // offset in half words
                imm = {{19{s}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            riscv_pkg::imm_src_jtype:
                imm = {{11{s}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            riscv_pkg::imm_src_utype:
                imm = {instr[31:12], 12'b0};
            default: // itype
                imm = {{20{s}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

`include "riscv_consts.svh"

module alu (
    input  wire riscv_pkg::word_t   a,
    input  wire riscv_pkg::word_t   b,
    input  wire riscv_pkg::alu_op_e op,
    output riscv_pkg::word_t        result,
    output riscv_pkg::alu_flags_t   flags
);

    logic             sub;
    riscv_pkg::word_t b_in;
    riscv_pkg::word_t sum;
    logic             cout;
    logic             ovf;

    // one adder, subtract as a + ~b + 1
    assign sub = (op == riscv_pkg::alu_op_sub) || (op == riscv_pkg::alu_op_slt)
              || (op == riscv_pkg::alu_op_sltu);
    assign b_in = sub ? ~b : b;
    assign {cout, sum} = {1'b0, a} + {1'b0, b_in} + {{`XLEN{1'b0}}, sub};

    // operands agree in sign but the sum does not
    assign ovf = (a[`XLEN-1] == b_in[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);

    always_comb begin
        case (op)
            riscv_pkg::alu_op_and:  result = a & b;
            riscv_pkg::alu_op_or:   result = a | b;
            riscv_pkg::alu_op_xor:  result = a ^ b;
            riscv_pkg::alu_op_sll:  result = a << b[4:0];
            riscv_pkg::alu_op_srl:  result = a >> b[4:0];
            riscv_pkg::alu_op_sra:  result = $signed(a) >>> b[4:0];
            riscv_pkg::alu_op_slt:  result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ ovf};
            riscv_pkg::alu_op_sltu: result = {{(`XLEN-1){1'b0}}, !cout}; // borrow
            default:                result = sum; // add, sub
        endcase
    end

    assign flags.neg  = result[`XLEN-1];
    assign flags.zero = (result == '0);
    assign flags.cout = cout;
    assign flags.ovf  = ovf;

endmodule

`default_nettype wire

//--- hdl/riscv_pkg.sv
`default_nettype none

`include "riscv_consts.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;
    typedef logic [6:0] opcode_t;

    // ALU operation, one per datapath function
    typedef enum logic [3:0] {
        alu_op_add,
        alu_op_sub,
        alu_op_and,
        alu_op_or,
        alu_op_xor,
        alu_op_sll,
        alu_op_srl,
        alu_op_sra,
        alu_op_slt,
        alu_op_sltu
    } alu_op_e;

    // operand selection, b is imm for both non-reg cases
    typedef enum logic [1:0] {
        alu_src_reg,
        alu_src_ext_imm,
        alu_src_pc_ext_imm // a = pc, for auipc
    } alu_src_e;

    typedef enum logic [1:0] {
        res_src_alu_out,
        res_src_read_data,
        res_src_pc_plus_4 // link value
    } res_src_e;

    typedef enum logic [1:0] {
        pc_src_plus_4,
        pc_src_plus_off,
        pc_src_reg_plus_off
    } pc_src_e;

    typedef enum logic [2:0] {
        imm_src_itype,
        imm_src_stype,
        imm_src_btype,
        imm_src_jtype,
        imm_src_utype
    } imm_src_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ovf;
    } alu_flags_t;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        alu_src_e alu_src;
        res_src_e result_src;
        pc_src_e  pc_src;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
    } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// machine word, also the address width
`define XLEN 32

// architectural integer registers, x0 included
`define NUM_REGS 32

// base opcodes, instr[6:0]
`define OP_LOAD   7'b0000011 // lw
`define OP_IMM    7'b0010011 // addi, andi, slli ...
`define OP_STORE  7'b0100011 // sw
`define OP_REG    7'b0110011 // add, sub, sll ...
`define OP_BRANCH 7'b1100011 // beq .. bgeu
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_AUIPC  7'b0010111

`endif
